// File: rtl/median_cfg_pkg.sv
`default_nettype none

package median_cfg_pkg;

  // width of one pixel sample
  localparam int SAMPLE_W = 8;

  // samples held in the sliding window
  localparam int WINDOW_LEN = 49;

  // zero-based slot of the middle value in the sorted chain
  localparam int MEDIAN_RANK = (WINDOW_LEN - 1) / 2;

  // enough bits to index every history entry
  localparam int PTR_W = $clog2(WINDOW_LEN);

  // values seen past the low and high ends of the chain
  localparam logic [SAMPLE_W-1:0] SENTINEL_LO = 8'h00;
  localparam logic [SAMPLE_W-1:0] SENTINEL_HI = 8'hff;

  // SENTINEL_HI also fills the window after reset, so the first medians are 255
  // until MEDIAN_RANK + 1 smaller samples have entered the window

endpackage

`default_nettype wire

// File: rtl/median_types_pkg.sv
`default_nettype none

package median_types_pkg;

  // one pixel sample as carried on the update bus and the chain
  typedef logic [median_cfg_pkg::SAMPLE_W-1:0] sample_t;

  // slot index into the history ring
  typedef logic [median_cfg_pkg::PTR_W-1:0] hist_ptr_t;

endpackage

`default_nettype wire

// File: rtl/window_history.sv
`timescale 1ns/10ps
`default_nettype none

module window_history (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire median_types_pkg::sample_t din,
  input  wire                       in_en,
  output median_types_pkg::sample_t upd_ins,
  output median_types_pkg::sample_t upd_del,
  output logic                      upd
);

  // ring of accepted samples, wr_ptr marks the oldest one
  median_types_pkg::sample_t ring [median_cfg_pkg::WINDOW_LEN];
  median_types_pkg::hist_ptr_t wr_ptr;
  median_types_pkg::hist_ptr_t wr_ptr_nxt;
  median_types_pkg::sample_t oldest;
  logic ptr_at_end;

  assign oldest = ring[wr_ptr];
  assign ptr_at_end = (wr_ptr == median_types_pkg::hist_ptr_t'(median_cfg_pkg::WINDOW_LEN - 1));

  // wrap at the window length
  always_comb begin
    if (ptr_at_end) begin
      wr_ptr_nxt = '0;
    end else begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      upd    <= 1'b0;
    end else begin
      upd <= in_en;
      if (in_en) begin
        wr_ptr <= wr_ptr_nxt;
      end
    end
  end

  // window starts out full of high sentinels, matching the cells
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < median_cfg_pkg::WINDOW_LEN; i++) begin
        ring[i] <= median_cfg_pkg::SENTINEL_HI;
      end
    end else if (in_en) begin
      ring[wr_ptr] <= din;
    end
  end

  // insert/delete pair for the rank cells
  always_ff @(posedge CLK) begin
    if (in_en) begin
      upd_ins <= din;
      upd_del <= oldest;
    end
  end

  a_ptr_in_range: assert property (
    @(posedge CLK) disable iff (RST)
    wr_ptr < median_cfg_pkg::WINDOW_LEN
  ) else $error("history pointer %0d left the window", wr_ptr);

endmodule

`default_nettype wire

// File: rtl/rank_cell.sv
`timescale 1ns/10ps
`default_nettype none

module rank_cell (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       upd,
  input  wire median_types_pkg::sample_t upd_ins,
  input  wire median_types_pkg::sample_t upd_del,
  input  wire median_types_pkg::sample_t pre,
  input  wire median_types_pkg::sample_t nxt,
  output median_types_pkg::sample_t val
);

  median_types_pkg::sample_t val_nxt;
  logic ins_lt_del;
  logic ins_gt_del;
  logic shift_up;
  logic shift_down;

  assign ins_lt_del = (upd_ins < upd_del);
  assign ins_gt_del = (upd_ins > upd_del);

  // slot sits between the two values, so it moves one place
  assign shift_up   = ins_lt_del && (val > upd_ins) && (val <= upd_del);
  assign shift_down = ins_gt_del && (val >= upd_del) && (val < upd_ins);

  always_comb begin
    val_nxt = val;
    if (shift_up) begin
      // take the lower neighbour or the new sample, whichever is larger
      val_nxt = (pre > upd_ins) ? pre : upd_ins;
    end else if (shift_down) begin
      val_nxt = (nxt < upd_ins) ? nxt : upd_ins;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      val <= median_cfg_pkg::SENTINEL_HI;
    end else if (upd) begin
      val <= val_nxt;
    end
  end

  a_hold_when_idle: assert property (
    @(posedge CLK) disable iff (RST)
    !upd |=> $stable(val)
  ) else $error("rank cell changed without an update");

  a_hold_when_same: assert property (
    @(posedge CLK) disable iff (RST)
    (upd && (upd_ins == upd_del)) |=> $stable(val)
  ) else $error("rank cell changed on equal insert and delete");

endmodule

`default_nettype wire

// File: rtl/median_tap.sv
`timescale 1ns/10ps
`default_nettype none

module median_tap (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       upd,
  input  wire median_types_pkg::sample_t cells [median_cfg_pkg::WINDOW_LEN],
  output median_types_pkg::sample_t dout,
  output logic                      out_valid
);

  // cells settle one edge after upd
  logic upd_d;
  logic in_order;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      upd_d     <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      upd_d     <= upd;
      out_valid <= upd_d;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      dout <= '0;
    end else if (upd_d) begin
      dout <= cells[median_cfg_pkg::MEDIAN_RANK];
    end
  end

  // whole chain must be ascending at capture
  always_comb begin
    in_order = 1'b1;
    for (int k = 0; k < median_cfg_pkg::WINDOW_LEN - 1; k++) begin
      if (cells[k] > cells[k + 1]) begin
        in_order = 1'b0;
      end
    end
  end

  a_chain_sorted: assert property (
    @(posedge CLK) disable iff (RST)
    upd_d |-> in_order
  ) else $error("rank chain out of order at median capture");

endmodule

`default_nettype wire

// File: rtl/running_median.sv
`timescale 1ns/10ps
`default_nettype none

module running_median (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire median_types_pkg::sample_t din,
  input  wire                       in_en,
  output median_types_pkg::sample_t dout,
  output logic                      out_valid
);

  // update bus from the history to every cell
  median_types_pkg::sample_t upd_ins;
  median_types_pkg::sample_t upd_del;
  logic upd;

  // sorted window, slot 0 holds the smallest sample
  median_types_pkg::sample_t cell_val [median_cfg_pkg::WINDOW_LEN];

  window_history u_history (
    .CLK     (CLK),
    .RST     (RST),
    .din     (din),
    .in_en   (in_en),
    .upd_ins (upd_ins),
    .upd_del (upd_del),
    .upd     (upd)
  );

  for (genvar k = 0; k < median_cfg_pkg::WINDOW_LEN; k++) begin : g_cell
    median_types_pkg::sample_t pre_v;
    median_types_pkg::sample_t nxt_v;

    // chain ends see the fixed sentinels
    if (k == 0) begin : g_lo
      assign pre_v = median_cfg_pkg::SENTINEL_LO;
    end else begin : g_pre
      assign pre_v = cell_val[k - 1];
    end

    if (k == median_cfg_pkg::WINDOW_LEN - 1) begin : g_hi
      assign nxt_v = median_cfg_pkg::SENTINEL_HI;
    end else begin : g_nxt
      assign nxt_v = cell_val[k + 1];
    end

    rank_cell u_cell (
      .CLK     (CLK),
      .RST     (RST),
      .upd     (upd),
      .upd_ins (upd_ins),
      .upd_del (upd_del),
      .pre     (pre_v),
      .nxt     (nxt_v),
      .val     (cell_val[k])
    );
  end

  median_tap u_tap (
    .CLK       (CLK),
    .RST       (RST),
    .upd       (upd),
    .cells     (cell_val),
    .dout      (dout),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

// File: tb/median_checker.sv
`timescale 1ns/10ps
`default_nettype none

module median_checker (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire median_types_pkg::sample_t din,
  input  wire                        in_en,
  input  wire median_types_pkg::sample_t dout,
  input  wire                        out_valid,
  output int                         value_errs,
  output int                         proto_errs,
  output int                         pending
);

  median_types_pkg::sample_t win [median_cfg_pkg::WINDOW_LEN];
  median_types_pkg::sample_t exp_q [$];
  int due_q [$];
  int wpos;
  int cyc;
  logic seen_out;

  // sort a copy of the window and pick the middle element
  function automatic median_types_pkg::sample_t ref_median(
    input median_types_pkg::sample_t w [median_cfg_pkg::WINDOW_LEN]
  );
    median_types_pkg::sample_t s [median_cfg_pkg::WINDOW_LEN];
    median_types_pkg::sample_t t;
    int j;
    s = w;
    for (int i = 1; i < median_cfg_pkg::WINDOW_LEN; i++) begin
      t = s[i];
      j = i - 1;
      while (j >= 0 && s[j] > t) begin
        s[j + 1] = s[j];
        j--;
      end
      s[j + 1] = t;
    end
    return s[median_cfg_pkg::MEDIAN_RANK];
  endfunction

  task automatic refill_window();
    for (int i = 0; i < median_cfg_pkg::WINDOW_LEN; i++) begin
      win[i] = median_cfg_pkg::SENTINEL_HI;
    end
    wpos = 0;
  endtask

  initial begin
    value_errs = 0;
    proto_errs = 0;
    pending = 0;
    cyc = 0;
    seen_out = 1'b0;
    refill_window();
  end

  always @(posedge CLK) begin
    cyc++;
    if (RST) begin
      refill_window();
      exp_q.delete();
      due_q.delete();
      seen_out = 1'b0;
      if (out_valid) begin
        $display("%0t: out_valid is high while reset is asserted", $time);
        proto_errs++;
      end
    end else begin
      if (out_valid) begin
        seen_out = 1'b1;
        if (exp_q.size() == 0) begin
          $display("%0t: out_valid pulse with no sample waiting for it", $time);
          proto_errs++;
        end else begin
          if (due_q[0] != cyc) begin
            $display("%0t: out_valid came early, due at cycle %0d", $time, due_q[0]);
            proto_errs++;
          end
          if (dout !== exp_q[0]) begin
            $display("[ERROR] %0t dout expected %0d got %0d", $time, exp_q[0], dout);
            value_errs++;
          end
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end else begin
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
          $display("%0t: out_valid missing for a sample due at cycle %0d", $time, due_q[0]);
          proto_errs++;
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
        if (!seen_out && dout !== '0) begin
          $display("[ERROR] %0t dout expected 0 got %0d", $time, dout);
          value_errs++;
        end
      end
      // result is driven after the second edge, so it is sampled at the third
      if (in_en) begin
        win[wpos] = din;
        wpos = (wpos == median_cfg_pkg::WINDOW_LEN - 1) ? 0 : wpos + 1;
        exp_q.push_back(ref_median(win));
        due_q.push_back(cyc + 3);
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// File: tb/tb_running_median.sv
`timescale 1ns/10ps
`default_nettype none

module tb_running_median;

  localparam int CLK_HALF = 20;
  localparam int DRV_DLY = 2;
  localparam int RST_CYCLES = 8;

  // samples per stimulus phase
  localparam int N_B2B = 120;
  localparam int N_GAP = 150;
  localparam int N_ZERO = 60;
  localparam int N_HIGH = 60;
  localparam int N_SAME = 80;
  localparam int N_PRE_RST = 30;
  localparam int N_POST_RST = 70;
  localparam int N_TOTAL = N_B2B + N_GAP + N_ZERO + N_HIGH + N_SAME + N_PRE_RST + N_POST_RST;
  localparam int TIMEOUT_MARGIN = 100;
  localparam int CYCLE_LIMIT = 4 * N_TOTAL + TIMEOUT_MARGIN;

  logic CLK;
  logic RST;
  logic in_en;
  logic out_valid;
  median_types_pkg::sample_t din;
  median_types_pkg::sample_t dout;
  int value_errs;
  int proto_errs;
  int pending;
  int cycle_cnt;
  integer seed;

  running_median uut (
    .CLK       (CLK),
    .RST       (RST),
    .din       (din),
    .in_en     (in_en),
    .dout      (dout),
    .out_valid (out_valid)
  );

  median_checker u_check (
    .CLK        (CLK),
    .RST        (RST),
    .din        (din),
    .in_en      (in_en),
    .dout       (dout),
    .out_valid  (out_valid),
    .value_errs (value_errs),
    .proto_errs (proto_errs),
    .pending    (pending)
  );

  always #CLK_HALF CLK = ~CLK;

  function automatic median_types_pkg::sample_t rand_sample();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic drive_cycle(input logic en, input median_types_pkg::sample_t data);
    @(posedge CLK);
    #DRV_DLY;
    in_en = en;
    din = data;
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, '0);
  endtask

  task automatic send_random(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b1, rand_sample());
    end
  endtask

  task automatic send_const(input int n, input median_types_pkg::sample_t value);
    repeat (n) drive_cycle(1'b1, value);
  endtask

  // strobes with 0..3 idle cycles between them, data keeps moving while idle
  task automatic send_gapped(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b1, rand_sample());
      r = $random(seed);
      repeat (r[1:0]) drive_cycle(1'b0, rand_sample());
    end
  endtask

  task automatic pulse_reset(input int n);
    @(posedge CLK);
    #DRV_DLY;
    RST = 1'b1;
    in_en = 1'b0;
    repeat (n) @(posedge CLK);
    #DRV_DLY;
    RST = 1'b0;
  endtask

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    CLK = 1'b0;
    RST = 1'b1;
    in_en = 1'b0;
    din = '0;
    cycle_cnt = 0;
    seed = 3;
    repeat (RST_CYCLES) @(posedge CLK);
    #DRV_DLY;
    RST = 1'b0;
    // quiet output after reset
    idle(10);
    send_random(N_B2B);
    idle(1);
    send_gapped(N_GAP);
    // extremes, then a run that ends with insert equal to delete
    send_const(N_ZERO, 8'h00);
    send_const(N_HIGH, 8'hff);
    send_const(N_SAME, 8'h5a);
    send_random(N_PRE_RST);
    pulse_reset(RST_CYCLES);
    idle(3);
    send_random(N_POST_RST);
    idle(1);
    while (pending != 0) @(posedge CLK);
    idle(5);
    $display("error count: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
rtl/median_cfg_pkg.sv
rtl/median_types_pkg.sv
rtl/window_history.sv
rtl/rank_cell.sv
rtl/median_tap.sv
rtl/running_median.sv
tb/median_checker.sv
tb/tb_running_median.sv

// File: Makefile
# Verilator build and run for the running median filter

VERILATOR ?= verilator
TOP       ?= tb_running_median
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Verification passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the simulation prints the pass message
test: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
